//--- Bender.yml
package:
  name: alu_cluster

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - alu_cluster_pkg.sv
      - operand_bypass.sv
      - int_alu_lane.sv
      - shift_lane.sv
      - alu_cluster.sv
  - target: test
    include_dirs:
      - .
    files:
      - alu_cluster_checker.sv
      - tb_alu_cluster.sv

//--- alu_cluster.sv
// two-lane integer cluster top with result bus history registers
`timescale 1ns/1ps

module alu_cluster import alu_cluster_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  word_t    ext_bus0,
  input  word_t    ext_bus1,
  input  logic     l0_issue_valid,
  input  opcode_t  l0_op,
  input  word_t    l0_a_val,
  input  word_t    l0_b_val,
  input  word_t    l0_c_val,
  input  src_sel_t l0_a_sel,
  input  src_sel_t l0_b_sel,
  input  src_sel_t l0_c_sel,
  input  imm_t     l0_imm,
  input  scale_t   l0_scale,
  input  logic     l1_issue_valid,
  input  opcode_t  l1_op,
  input  word_t    l1_a_val,
  input  word_t    l1_b_val,
  input  src_sel_t l1_a_sel,
  input  src_sel_t l1_b_sel,
  output word_t    res0,
  output flags_t   res0_flags,
  output logic     res0_valid,
  output word_t    res1,
  output flags_t   res1_flags,
  output logic     res1_valid
);

  word_t ext_bus0_old;
  word_t ext_bus1_old;
  word_t res0_old;
  word_t res1_old;

  // one-cycle-old copy of every bus.
  always_ff @(posedge clk) begin
    ext_bus0_old <= ext_bus0;
    ext_bus1_old <= ext_bus1;
    res0_old     <= res0;
    res1_old     <= res1;
  end

  //////////////////////////////
  int_alu_lane u_int_lane (
    .clk, .rst_n, .issue_valid(l0_issue_valid), .op(l0_op),
    .a_val(l0_a_val), .b_val(l0_b_val), .c_val(l0_c_val),
    .a_sel(l0_a_sel), .b_sel(l0_b_sel), .c_sel(l0_c_sel),
    .imm(l0_imm), .scale(l0_scale),
    .bus_now0(ext_bus0), .bus_now1(ext_bus1), .bus_now2(res0), .bus_now3(res1),
    .bus_old0(ext_bus0_old), .bus_old1(ext_bus1_old),
    .bus_old2(res0_old), .bus_old3(res1_old),
    .res(res0), .res_flags(res0_flags), .res_valid(res0_valid)
  );

  shift_lane u_shift_lane (
    .clk, .rst_n, .issue_valid(l1_issue_valid), .op(l1_op),
    .a_val(l1_a_val), .b_val(l1_b_val), .a_sel(l1_a_sel), .b_sel(l1_b_sel),
    .bus_now0(ext_bus0), .bus_now1(ext_bus1), .bus_now2(res0), .bus_now3(res1),
    .bus_old0(ext_bus0_old), .bus_old1(ext_bus1_old),
    .bus_old2(res0_old), .bus_old3(res1_old),
    .res(res1), .res_flags(res1_flags), .res_valid(res1_valid)
  );

endmodule

//--- alu_cluster_checker.sv
// concurrent checks on result strobes and result values of the ALU cluster
`timescale 1ns/1ps

module alu_cluster_checker import alu_cluster_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  l0_issue_valid,
  input logic  l1_issue_valid,
  input logic  res0_valid,
  input logic  res1_valid,
  input word_t res0,
  input word_t res1
);

  int unsigned err_cnt = 0;

  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !res0_valid && !res1_valid)
    else begin
      err_cnt++;
      $error("result strobe high while reset is asserted");
    end

  // both lanes have a fixed two cycle latency.
  a_lat_l0: assert property (@(posedge clk) disable iff (!rst_n)
                             res0_valid == $past(l0_issue_valid, 2))
    else begin
      err_cnt++;
      $error("res0_valid does not follow the lane 0 issue by two cycles");
    end

  a_lat_l1: assert property (@(posedge clk) disable iff (!rst_n)
                             res1_valid == $past(l1_issue_valid, 2))
    else begin
      err_cnt++;
      $error("res1_valid does not follow the lane 1 issue by two cycles");
    end

  a_known: assert property (@(posedge clk) disable iff (!rst_n)
                            (!res0_valid || !$isunknown(res0)) &&
                            (!res1_valid || !$isunknown(res1)))
    else begin
      err_cnt++;
      $error("unknown bits on a result bus while its strobe is high");
    end

endmodule

//--- alu_cluster_defs.svh
// data widths, opcode codes, operand source codes and flag bit positions
`ifndef ALU_CLUSTER_DEFS_SVH
`define ALU_CLUSTER_DEFS_SVH

`define ALU_XLEN    64
`define ALU_OP_W    4
`define ALU_SEL_W   4
`define ALU_SCALE_W 2
`define ALU_IMM_W   32
`define ALU_NBUS    4

// integer lane.
`define OP_ADD 4'd1
`define OP_SUB 4'd2
`define OP_CMP 4'd3
`define OP_AND 4'd4
`define OP_OR  4'd5
`define OP_XOR 4'd6
`define OP_LEA 4'd7
`define OP_SHL 4'd8  // shift lane.
`define OP_SHR 4'd9
`define OP_SAR 4'd10

// bus index goes in the low two bits of a bus source code.
`define SRC_REG     4'd0
`define SRC_BUS_NOW 4'd4
`define SRC_BUS_OLD 4'd8

`define FLG_Z 3
`define FLG_C 2
`define FLG_S 1
`define FLG_O 0
`endif

//--- alu_cluster_pkg.sv
// vector typedefs shared by the ALU cluster blocks
`include "alu_cluster_defs.svh"

package alu_cluster_pkg;

  // data word carried on operands and result buses.
  typedef logic [`ALU_XLEN-1:0] word_t;

  typedef logic [`ALU_OP_W-1:0] opcode_t;

  // register, current bus or previous bus.
  typedef logic [`ALU_SEL_W-1:0] src_sel_t;

  // zero, carry, sign, overflow from msb down.
  typedef logic [3:0] flags_t;

  // address constant, sign-extended when added.
  typedef logic [`ALU_IMM_W-1:0] imm_t;

  typedef logic [`ALU_SCALE_W-1:0] scale_t;  // index shift 0..3.

endpackage

//--- int_alu_lane.sv
// integer lane with add/sub/compare, logic ops, flags and address adder
`timescale 1ns/1ps
`include "alu_cluster_defs.svh"

module int_alu_lane import alu_cluster_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue_valid,
  input  opcode_t  op,
  input  word_t    a_val,
  input  word_t    b_val,
  input  word_t    c_val,
  input  src_sel_t a_sel,
  input  src_sel_t b_sel,
  input  src_sel_t c_sel,
  input  imm_t     imm,
  input  scale_t   scale,
  input  word_t    bus_now0,
  input  word_t    bus_now1,
  input  word_t    bus_now2,
  input  word_t    bus_now3,
  input  word_t    bus_old0,
  input  word_t    bus_old1,
  input  word_t    bus_old2,
  input  word_t    bus_old3,
  output word_t    res,
  output flags_t   res_flags,
  output logic     res_valid
);

  word_t              a_q;
  word_t              b_q;
  word_t              c_q;
  logic               v1_q;
  logic               arith_q;
  logic               sub_q;
  logic               cmp_q;
  logic               lea_q;
  logic [1:0]         logic_q;  // 1 and, 2 or, 3 xor.
  imm_t               imm_q;
  scale_t             scale_q;
  word_t              b_eff;
  logic [`ALU_XLEN:0] sum;
  logic               carry;
  logic               ovf;
  word_t              logic_r;
  word_t              ea;
  word_t              res_d;
  flags_t             flags_d;

  operand_bypass u_a_byp (
    .clk, .rst_n, .issue_valid, .sel(a_sel), .reg_val(a_val),
    .bus_now0, .bus_now1, .bus_now2, .bus_now3,
    .bus_old0, .bus_old1, .bus_old2, .bus_old3, .opnd(a_q)
  );
  operand_bypass u_b_byp (
    .clk, .rst_n, .issue_valid, .sel(b_sel), .reg_val(b_val),
    .bus_now0, .bus_now1, .bus_now2, .bus_now3,
    .bus_old0, .bus_old1, .bus_old2, .bus_old3, .opnd(b_q)
  );
  operand_bypass u_c_byp (
    .clk, .rst_n, .issue_valid, .sel(c_sel), .reg_val(c_val),
    .bus_now0, .bus_now1, .bus_now2, .bus_now3,
    .bus_old0, .bus_old1, .bus_old2, .bus_old3, .opnd(c_q)
  );

  //////////////////////////////
  // stage 1 decode.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1_q    <= 1'b0;
      arith_q <= 1'b0;
      sub_q   <= 1'b0;
      cmp_q   <= 1'b0;
      lea_q   <= 1'b0;
      logic_q <= 2'd0;
    end else begin
      v1_q <= issue_valid;
      if (issue_valid) begin
        arith_q <= op == `OP_ADD || op == `OP_SUB || op == `OP_CMP;
        sub_q   <= op == `OP_SUB || op == `OP_CMP;
        cmp_q   <= op == `OP_CMP;
        lea_q   <= op == `OP_LEA;
        logic_q <= (op == `OP_AND) ? 2'd1 : (op == `OP_OR) ? 2'd2 :
                   (op == `OP_XOR) ? 2'd3 : 2'd0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      imm_q   <= imm;
      scale_q <= scale;
    end
  end

  //////////////////////////////
  // stage 2 execute.
  assign b_eff = sub_q ? ~b_q : b_q;
  assign sum   = {1'b0, a_q} + {1'b0, b_eff} + {{`ALU_XLEN{1'b0}}, sub_q};
  assign carry = sum[`ALU_XLEN] ^ sub_q;  // borrow on subtract.
  assign ovf   = (a_q[`ALU_XLEN-1] == b_eff[`ALU_XLEN-1]) &&
                 (sum[`ALU_XLEN-1] != a_q[`ALU_XLEN-1]);
  assign ea    = a_q + (c_q << scale_q) +
                 {{(`ALU_XLEN-`ALU_IMM_W){imm_q[`ALU_IMM_W-1]}}, imm_q};

  always_comb begin
    case (logic_q)
      2'd1:    logic_r = a_q & b_q;
      2'd2:    logic_r = a_q | b_q;
      2'd3:    logic_r = a_q ^ b_q;
      default: logic_r = '0;
    endcase
    res_d   = '0;
    flags_d = '0;
    if (arith_q) begin
      res_d = sum[`ALU_XLEN-1:0];
      flags_d[`FLG_C] = carry;
      flags_d[`FLG_O] = ovf;
    end else if (logic_q != 2'd0) begin
      res_d = logic_r;
    end else if (lea_q) begin
      res_d = ea;  // address ops leave flags clear.
    end
    if (arith_q || logic_q != 2'd0) begin
      flags_d[`FLG_Z] = res_d == '0;
      flags_d[`FLG_S] = res_d[`ALU_XLEN-1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res       <= '0;
      res_flags <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= v1_q;
      if (v1_q) begin
        if (!cmp_q) res <= res_d;  // compare only updates flags.
        res_flags <= flags_d;
      end
    end
  end

endmodule

//--- operand_bypass.sv
// operand source select and issue register for one lane operand
`timescale 1ns/1ps
`include "alu_cluster_defs.svh"

module operand_bypass import alu_cluster_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue_valid,
  input  src_sel_t sel,
  input  word_t    reg_val,
  input  word_t    bus_now0,
  input  word_t    bus_now1,
  input  word_t    bus_now2,
  input  word_t    bus_now3,
  input  word_t    bus_old0,
  input  word_t    bus_old1,
  input  word_t    bus_old2,
  input  word_t    bus_old3,
  output word_t    opnd
);

  word_t now_w [`ALU_NBUS];
  word_t old_w [`ALU_NBUS];
  logic  use_now;
  logic  use_old;
  word_t opnd_d;

  assign now_w = '{bus_now0, bus_now1, bus_now2, bus_now3};
  assign old_w = '{bus_old0, bus_old1, bus_old2, bus_old3};

  assign use_now = {sel[3:2], 2'b00} == `SRC_BUS_NOW;
  assign use_old = {sel[3:2], 2'b00} == `SRC_BUS_OLD;

  // anything that is not a bus code falls back to the register read.
  assign opnd_d = use_now ? now_w[sel[1:0]] :
                  use_old ? old_w[sel[1:0]] : reg_val;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opnd <= '0;
    end else if (issue_valid) begin
      opnd <= opnd_d;  // held until the next issue.
    end
  end

endmodule

//--- shift_lane.sv
// shift lane with shl/shr/sar barrel shifter and zero/sign flags
`timescale 1ns/1ps
`include "alu_cluster_defs.svh"

module shift_lane import alu_cluster_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue_valid,
  input  opcode_t  op,
  input  word_t    a_val,
  input  word_t    b_val,
  input  src_sel_t a_sel,
  input  src_sel_t b_sel,
  input  word_t    bus_now0,
  input  word_t    bus_now1,
  input  word_t    bus_now2,
  input  word_t    bus_now3,
  input  word_t    bus_old0,
  input  word_t    bus_old1,
  input  word_t    bus_old2,
  input  word_t    bus_old3,
  output word_t    res,
  output flags_t   res_flags,
  output logic     res_valid
);

  localparam int SHAMT_W = $clog2(`ALU_XLEN);

  word_t              a_q;
  word_t              b_q;
  logic               v1_q;
  logic               sh_en_q;
  logic               dir_q;  // 1 shifts right.
  logic               arith_q;
  logic [SHAMT_W-1:0] amt;
  word_t              sh_r;

  operand_bypass u_a_byp (
    .clk, .rst_n, .issue_valid, .sel(a_sel), .reg_val(a_val),
    .bus_now0, .bus_now1, .bus_now2, .bus_now3,
    .bus_old0, .bus_old1, .bus_old2, .bus_old3, .opnd(a_q)
  );
  operand_bypass u_b_byp (
    .clk, .rst_n, .issue_valid, .sel(b_sel), .reg_val(b_val),
    .bus_now0, .bus_now1, .bus_now2, .bus_now3,
    .bus_old0, .bus_old1, .bus_old2, .bus_old3, .opnd(b_q)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1_q    <= 1'b0;
      sh_en_q <= 1'b0;
      dir_q   <= 1'b0;
      arith_q <= 1'b0;
    end else begin
      v1_q <= issue_valid;
      if (issue_valid) begin
        sh_en_q <= op == `OP_SHL || op == `OP_SHR || op == `OP_SAR;
        dir_q   <= op == `OP_SHR || op == `OP_SAR;
        arith_q <= op == `OP_SAR;
      end
    end
  end

  assign amt = b_q[SHAMT_W-1:0];

  always_comb begin
    if (!sh_en_q)     sh_r = '0;
    else if (!dir_q)  sh_r = a_q << amt;
    else if (arith_q) sh_r = $signed(a_q) >>> amt;
    else              sh_r = a_q >> amt;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res       <= '0;
      res_flags <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= v1_q;
      if (v1_q) begin
        res       <= sh_r;
        res_flags <= {sh_en_q && sh_r == '0, 1'b0, sh_r[`ALU_XLEN-1], 1'b0};
      end
    end
  end

endmodule

//--- tb_alu_cluster.sv
// testbench for the ALU cluster with stimulus table, reference model and watchdog
`timescale 1ns/1ps
`include "alu_cluster_defs.svh"

module tb_alu_cluster import alu_cluster_pkg::*; ();

  localparam int RST_CYCLES = 10;
  localparam int N_RAND     = 24;

  localparam src_sel_t REG    = `SRC_REG;
  localparam src_sel_t NOW_X0 = `SRC_BUS_NOW | 4'd0;
  localparam src_sel_t NOW_X1 = `SRC_BUS_NOW | 4'd1;
  localparam src_sel_t NOW_R0 = `SRC_BUS_NOW | 4'd2;
  localparam src_sel_t NOW_R1 = `SRC_BUS_NOW | 4'd3;
  localparam src_sel_t OLD_X0 = `SRC_BUS_OLD | 4'd0;
  localparam src_sel_t OLD_R0 = `SRC_BUS_OLD | 4'd2;
  localparam src_sel_t OLD_R1 = `SRC_BUS_OLD | 4'd3;

  // one issue cycle of both lanes, plus the outputs expected after it.
  typedef struct packed {
    logic     v0;
    opcode_t  op0;
    word_t    a0, b0, c0;
    src_sel_t as0, bs0, cs0;
    imm_t     imm;
    scale_t   scale;
    logic     v1;
    opcode_t  op1;
    word_t    a1, b1;
    src_sel_t as1, bs1;
    word_t    e0, e1;
    word_t    r0, r1;
    flags_t   f0, f1;
  } row_t;

  logic     clk;
  logic     rst_n;
  word_t    ext_bus0, ext_bus1;
  logic     l0_issue_valid, l1_issue_valid;
  opcode_t  l0_op, l1_op;
  word_t    l0_a_val, l0_b_val, l0_c_val, l1_a_val, l1_b_val;
  src_sel_t l0_a_sel, l0_b_sel, l0_c_sel, l1_a_sel, l1_b_sel;
  imm_t     l0_imm;
  scale_t   l0_scale;
  word_t    res0, res1;
  flags_t   res0_flags, res1_flags;
  logic     res0_valid, res1_valid;

  row_t        tbl[$];
  string       names[$];
  row_t        cur;
  int          n_rows = 0;
  logic [31:0] lcg_state = 32'h312c_3fb6;

  alu_cluster u_alu_cluster (.*);

  bind alu_cluster alu_cluster_checker u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t rand_word();
    return {lcg_next(), lcg_next()};
  endfunction

  function automatic word_t pick_src(input src_sel_t s, input word_t rv,
                                     input logic [3:0][`ALU_XLEN-1:0] now_b,
                                     input logic [3:0][`ALU_XLEN-1:0] old_b);
    case (s[3:2])
      2'd1:    return now_b[s[1:0]];
      2'd2:    return old_b[s[1:0]];
      default: return rv;
    endcase
  endfunction

  // flags are {zero, carry, sign, overflow}; carry is the borrow on subtract.
  function automatic void int_ref(input opcode_t op, input word_t a, input word_t b,
                                  input word_t c, input imm_t imm, input scale_t sc,
                                  inout word_t r, inout flags_t f);
    logic [`ALU_XLEN:0] full;
    word_t              diff;
    diff = a - b;
    full = {1'b0, a} + {1'b0, b};
    case (op)
      `OP_ADD: begin
        r = full[`ALU_XLEN-1:0];
        f = {r == '0, full[`ALU_XLEN], r[63], a[63] == b[63] && r[63] != a[63]};
      end
      `OP_SUB, `OP_CMP: begin
        f = {diff == '0, a < b, diff[63], a[63] != b[63] && diff[63] != a[63]};
        if (op == `OP_SUB) r = diff;  // compare keeps the old bus value.
      end
      `OP_AND, `OP_OR, `OP_XOR: begin
        r = (op == `OP_AND) ? a & b : (op == `OP_OR) ? a | b : a ^ b;
        f = {r == '0, 1'b0, r[63], 1'b0};
      end
      `OP_LEA: begin
        r = a + (c << sc) + {{32{imm[31]}}, imm};
        f = '0;
      end
      default: begin
        r = '0;
        f = '0;
      end
    endcase
  endfunction

  function automatic void shift_ref(input opcode_t op, input word_t a, input word_t b,
                                    inout word_t r, inout flags_t f);
    int amt;
    amt = b[5:0];
    case (op)
      `OP_SHL: r = a << amt;
      `OP_SHR: r = a >> amt;
      `OP_SAR: r = (a >> amt) | (a[63] ? ~({`ALU_XLEN{1'b1}} >> amt) : '0);
      default: r = '0;
    endcase
    f = {r == '0 && op inside {`OP_SHL, `OP_SHR, `OP_SAR}, 1'b0, r[63], 1'b0};
  endfunction

  //////////////////////////////
  task automatic int_op(opcode_t op, word_t a, word_t b, src_sel_t as, src_sel_t bs);
    cur.v0  = 1'b1;
    cur.op0 = op;
    cur.a0  = a;
    cur.b0  = b;
    cur.as0 = as;
    cur.bs0 = bs;
  endtask

  task automatic lea_op(word_t a, word_t c, imm_t imm, scale_t sc);
    cur.v0    = 1'b1;
    cur.op0   = `OP_LEA;
    cur.a0    = a;
    cur.c0    = c;
    cur.imm   = imm;
    cur.scale = sc;
  endtask

  task automatic shift_op(opcode_t op, word_t a, word_t b, src_sel_t as, src_sel_t bs);
    cur.v1  = 1'b1;
    cur.op1 = op;
    cur.a1  = a;
    cur.b1  = b;
    cur.as1 = as;
    cur.bs1 = bs;
  endtask

  task automatic push_row(string name, word_t e0, word_t e1);
    cur.e0 = e0;
    cur.e1 = e1;
    tbl.push_back(cur);
    names.push_back(name);
    cur = '0;
  endtask

  task automatic build_table();
    logic [31:0] x;
    cur = '0;
    int_op(`OP_ADD, 64'd5, 64'd7, REG, REG);
    shift_op(`OP_SHL, 64'h8000_0000_0000_0001, 64'd0, REG, REG);
    push_row("add_shl0", 64'd0, 64'd0);
    int_op(`OP_ADD, '1, 64'd1, REG, REG);
    shift_op(`OP_SHL, 64'd3, 64'h7fff, REG, REG);  // amount 63 from the low six bits.
    push_row("add_carry_shl63", 64'd0, 64'd0);
    int_op(`OP_ADD, 64'h7fff_ffff_ffff_ffff, 64'd1, REG, REG);
    shift_op(`OP_SHR, 64'h8000_0000_0000_0000, 64'd63, REG, REG);
    push_row("add_ovf_shr63", 64'd0, 64'd0);
    int_op(`OP_SUB, 64'd0, 64'd1, REG, REG);
    shift_op(`OP_SAR, 64'h8000_0000_0000_0000, 64'd63, REG, REG);
    push_row("sub_borrow_sar63", 64'd0, 64'd0);
    int_op(`OP_SUB, 64'h8000_0000_0000_0000, 64'd1, REG, REG);
    shift_op(`OP_SAR, 64'hf000_0000_0000_0000, 64'd4, REG, REG);
    push_row("sub_ovf_sar4", 64'd0, 64'd0);
    int_op(`OP_CMP, 64'd3, 64'd3, REG, REG);
    shift_op(`OP_SHR, 64'd0, 64'd5, REG, REG);
    push_row("cmp_eq_shr_zero", 64'd0, 64'd0);
    int_op(`OP_CMP, 64'd1, 64'd2, REG, REG);
    push_row("cmp_lt", 64'd0, 64'd0);
    int_op(`OP_AND, 64'hf0f0_f0f0_0000_ffff, 64'hff00_ff00_1234_00ff, REG, REG);
    shift_op(`OP_ADD, 64'd9, 64'd1, REG, REG);  // not a shift op.
    push_row("and_bad_shift", 64'd0, 64'd0);
    int_op(`OP_OR, 64'h8000_0000_0000_0000, 64'd1, REG, REG);
    push_row("or", 64'd0, 64'd0);
    int_op(`OP_XOR, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0, REG, REG);
    push_row("xor_zero", 64'd0, 64'd0);
    lea_op(64'd1000, 64'd3, 32'hffff_fff8, 2'd0);
    push_row("lea_s0", 64'd0, 64'd0);
    lea_op(64'd1000, 64'd3, 32'd16, 2'd1);
    push_row("lea_s1", 64'd0, 64'd0);
    lea_op(64'hffff_ffff_ffff_fff0, 64'd5, 32'h7fff_ffff, 2'd2);
    push_row("lea_s2", 64'd0, 64'd0);
    lea_op(64'd0, 64'd8, 32'h8000_0000, 2'd3);
    push_row("lea_s3", 64'd0, 64'd0);
    int_op(4'd0, 64'd1, 64'd1, REG, REG);
    push_row("bad_int_op", 64'd0, 64'd0);
    push_row("idle", 64'd0, 64'd0);
    int_op(`OP_ADD, 64'd0, 64'd0, NOW_X0, NOW_X1);
    shift_op(`OP_SHL, 64'd0, 64'd4, NOW_X1, REG);
    push_row("byp_ext_now", 64'd100, 64'd200);
    int_op(`OP_SUB, 64'd0, 64'd0, OLD_X0, NOW_X1);
    shift_op(`OP_SHR, 64'd0, 64'd1, NOW_R0, REG);
    push_row("byp_ext_old", 64'd7, 64'd9);
    int_op(`OP_ADD, 64'd0, 64'd1, NOW_R0, REG);
    shift_op(`OP_SHL, 64'd0, 64'd0, NOW_R1, NOW_R0);
    push_row("dep_now", 64'd0, 64'd0);
    int_op(`OP_ADD, 64'd0, 64'd0, NOW_R0, OLD_R0);
    shift_op(`OP_SAR, 64'd0, 64'd2, OLD_R1, REG);
    push_row("dep_now_old", 64'd0, 64'd0);
    int_op(`OP_XOR, 64'd0, 64'd0, OLD_R1, NOW_R0);
    push_row("dep_cross", 64'd0, 64'd0);
    for (int i = 0; i < N_RAND; i++) begin
      x = lcg_next();
      cur.v0    = x[0] | x[1];
      cur.op0   = {1'b0, x[4:2]};
      cur.as0   = x[8:5];
      cur.bs0   = x[12:9];
      cur.cs0   = x[16:13];
      cur.scale = x[18:17];
      cur.v1    = x[19] | x[20];
      cur.op1   = (x[22:21] == 2'd3) ? 4'd0 : `OP_SHL + x[22:21];
      cur.as1   = x[26:23];
      cur.bs1   = x[30:27];
      cur.a0    = rand_word();
      cur.b0    = rand_word();
      cur.c0    = rand_word();
      cur.a1    = rand_word();
      cur.b1    = rand_word();
      cur.imm   = lcg_next();
      push_row($sformatf("random_%0d", i), rand_word(), rand_word());
    end
  endtask

  // a row's operands see the outputs of two rows back now and three rows back as old.
  task automatic build_expected();
    logic [3:0][`ALU_XLEN-1:0] now_b;
    logic [3:0][`ALU_XLEN-1:0] old_b;
    row_t   t;
    row_t   prev1;
    row_t   prev2;
    word_t  r;
    flags_t f;
    old_b = '0;
    prev1 = '0;
    prev2 = '0;
    foreach (tbl[k]) begin
      t = tbl[k];
      now_b = {prev2.r1, prev2.r0, t.e1, t.e0};
      r = prev1.r0;
      f = prev1.f0;
      if (t.v0) begin
        int_ref(t.op0, pick_src(t.as0, t.a0, now_b, old_b), pick_src(t.bs0, t.b0, now_b, old_b),
                pick_src(t.cs0, t.c0, now_b, old_b), t.imm, t.scale, r, f);
      end
      t.r0 = r;
      t.f0 = f;
      r = prev1.r1;
      f = prev1.f1;
      if (t.v1) begin
        shift_ref(t.op1, pick_src(t.as1, t.a1, now_b, old_b),
                  pick_src(t.bs1, t.b1, now_b, old_b), r, f);
      end
      t.r1 = r;
      t.f1 = f;
      tbl[k] = t;
      old_b = now_b;
      prev2 = prev1;
      prev1 = t;
    end
  endtask

  //////////////////////////////
  task automatic drive_row(row_t t);
    ext_bus0       = t.e0;
    ext_bus1       = t.e1;
    l0_issue_valid = t.v0;
    l0_op          = t.op0;
    l0_a_val       = t.a0;
    l0_b_val       = t.b0;
    l0_c_val       = t.c0;
    l0_a_sel       = t.as0;
    l0_b_sel       = t.bs0;
    l0_c_sel       = t.cs0;
    l0_imm         = t.imm;
    l0_scale       = t.scale;
    l1_issue_valid = t.v1;
    l1_op          = t.op1;
    l1_a_val       = t.a1;
    l1_b_val       = t.b1;
    l1_a_sel       = t.as1;
    l1_b_sel       = t.bs1;
  endtask

  task automatic report_mismatch(string what, word_t exp, word_t act);
    $display("ERROR %s: expected %h actual %h", what, exp, act);
    $display("TEST FAIL");
    $fatal(1, "result mismatch");
  endtask

  task automatic check_row(string name, row_t t);
    assert (res0_valid === t.v0 && res1_valid === t.v1)
      else report_mismatch({name, " valid"}, {t.v0, t.v1}, {res0_valid, res1_valid});
    assert (res0 === t.r0) else report_mismatch({name, " res0"}, t.r0, res0);
    assert (res0_flags === t.f0)
      else report_mismatch({name, " res0_flags"}, t.f0, res0_flags);
    assert (res1 === t.r1) else report_mismatch({name, " res1"}, t.r1, res1);
    assert (res1_flags === t.f1)
      else report_mismatch({name, " res1_flags"}, t.f1, res1_flags);
  endtask

  initial begin
    wait (n_rows > 0);
    repeat (n_rows + 20) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", n_rows + 20);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n = 1'b0;
    drive_row('0);
    build_table();
    build_expected();
    n_rows = tbl.size();
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int k = 0; k < n_rows + 2; k++) begin
      @(negedge clk);
      if (k < 2) check_row("after_reset", '0);  // nothing has come out yet.
      else check_row(names[k-2], tbl[k-2]);
      if (k < n_rows) drive_row(tbl[k]);
      else drive_row('0);
    end
    if (u_alu_cluster.u_checker.err_cnt != 0) begin
      $display("checker assertions failed %0d times", u_alu_cluster.u_checker.err_cnt);
      $display("TEST FAIL");
      $fatal(1, "checker assertions failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- vlog.f
+incdir+.
alu_cluster_pkg.sv
operand_bypass.sv
int_alu_lane.sv
shift_lane.sv
alu_cluster.sv
alu_cluster_checker.sv
tb_alu_cluster.sv
